/* Bender.yml */
package:
  name: sparc_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sparcCtrlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/ctrlSequencer.sv
      - verilog/ctrlWordGen.sv
      - verilog/controlUnit.sv
  - target: test
    files:
      - tb/controlUnitTb.sv

/* tb/controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb;

	localparam int NUM_INSTR = 40;
	localparam int CYCLE_LIMIT = 1500; // 40 instructions of up to 25 cycles, reset and margin
	localparam logic [29:0] LOAD_OPS = {6'h00, 6'h01, 6'h02, 6'h09, 6'h0A};
	localparam logic [17:0] STORE_OPS = {6'h04, 6'h05, 6'h06};

	// Expected fields of the instruction being executed
	typedef struct packed
	{
		sparcCtrlPkg::instrClass_e cls;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic imm;
		logic [5:0] op3;
		logic jump; // Taken and not annulled
		logic skip; // Not taken and annulled
	} trackedInstr_t;

	logic Clk;
	logic RESET;
	logic [31:0] Ir;
	logic Mfc;
	logic Cond;
	sparcCtrlPkg::ctrlWord_t Ctrl;

	logic [31:0] instrList [NUM_INSTR];
	sparcCtrlPkg::instrClass_e instrCls [NUM_INSTR];
	trackedInstr_t trk;
	int errorCount;
	int presented;
	int cycleCount;
	int resetEdges;
	int rstNpcPulses;
	int mfcDelay;
	int branchesBuilt;
	logic marSeen;
	logic dataPending; // Next MarEn belongs to a load or store
	logic accIsFetch;
	logic accIsStore;
	logic finished;
	logic anyEnable;
	logic allClears;

	controlUnit uut (
		.Clk   (Clk),
		.RESET (RESET),
		.Ir    (Ir),
		.Mfc   (Mfc),
		.Cond  (Cond),
		.Ctrl  (Ctrl)
	);

	assign anyEnable = Ctrl.IrEn || Ctrl.NpcEn || Ctrl.PcEn || Ctrl.MdrEn || Ctrl.MarEn
		|| Ctrl.RegWrite || Ctrl.RamEn || Ctrl.PsrEn;
	assign allClears = Ctrl.PcClr && Ctrl.TrPrClr && Ctrl.TbrClr && Ctrl.PsrClr;

	always #5 Clk = ~Clk;

	task automatic mismatch(input string name, input int expected, input int actual);
		errorCount++;
		$display("error %s: expected %0d, actual %0d", name, expected, actual);
	endtask

	task automatic fault(input string what);
		errorCount++;
		$display("check failed at %0t: %s", $time, what);
	endtask

	// Random legal instruction of one class, variant picks the branch flavor
	function automatic logic [31:0] buildInstr(input sparcCtrlPkg::instrClass_e cls,
		input int variant);
		logic [31:0] r;
		logic [3:0] cond;
		logic annul;
		r = $urandom;
		cond = 4'($urandom_range(7, 1)) + (r[28] ? 4'd8 : 4'd0); // Never 0000 or 1000
		annul = r[29];
		case (variant % 4)
			0:
			begin
				cond = 4'b1000;
				annul = 1'b0;
			end
			1:
			begin
				cond = 4'b0000;
				annul = 1'b1;
			end
			3:
			begin
				cond = 4'b1000;
				annul = 1'b1;
			end
			default: ;
		endcase
		case (cls)
			sparcCtrlPkg::ClsSethi:  r[31:22] = {2'b00, r[29:25], 3'b100};
			sparcCtrlPkg::ClsBranch: r[31:22] = {2'b00, annul, cond, 3'b010};
			sparcCtrlPkg::ClsCall:   r[31:30] = 2'b01;
			sparcCtrlPkg::ClsJmpl:   r[31:19] = {2'b10, r[29:25], 6'b111000};
			sparcCtrlPkg::ClsArith:  r[31:19] = {2'b10, r[29:25], 1'b0, r[23:19]};
			sparcCtrlPkg::ClsLoad:
				r[31:19] = {2'b11, r[29:25], LOAD_OPS[6 * $urandom_range(4, 0) +: 6]};
			default:
				r[31:19] = {2'b11, r[29:25], STORE_OPS[6 * $urandom_range(2, 0) +: 6]};
		endcase
		return r;
	endfunction

	function automatic trackedInstr_t expectedFields(input logic [31:0] w,
		input sparcCtrlPkg::instrClass_e cls, input logic condBit);
		trackedInstr_t t;
		logic isBranch;
		logic isCondKind;
		isBranch = cls == sparcCtrlPkg::ClsBranch;
		isCondKind = w[27:25] != 3'b000; // Neither always nor never
		t.cls = cls;
		t.rd = w[29:25];
		t.rs1 = w[18:14];
		t.rs2 = w[4:0];
		t.imm = w[13];
		t.op3 = w[24:19];
		t.jump = isBranch && !w[29] && (w[28:25] == 4'b1000 || (isCondKind && condBit));
		t.skip = isBranch && w[29] && (w[28:25] == 4'b0000 || (isCondKind && !condBit));
		return t;
	endfunction

	initial
	begin
		void'($urandom(8));
		Clk = 1'b0;
		RESET = 1'b1;
		Ir = '0;
		Mfc = 1'b0;
		Cond = 1'b0;
		trk = '0;
		trk.cls = sparcCtrlPkg::ClsIllegal;
		errorCount = 0;
		presented = 0;
		cycleCount = 0;
		resetEdges = 0;
		rstNpcPulses = 0;
		branchesBuilt = 0;
		marSeen = 1'b0;
		dataPending = 1'b0;
		accIsFetch = 1'b1;
		accIsStore = 1'b0;
		finished = 1'b0;
		mfcDelay = $urandom_range(3, 0);
		for (int i = 0; i < NUM_INSTR; i++)
		begin
			if (i < 14)
				instrCls[i] = sparcCtrlPkg::instrClass_e'(i % 7); // Every class twice first
			else
				instrCls[i] = sparcCtrlPkg::instrClass_e'($urandom_range(6, 0));
			instrList[i] = buildInstr(instrCls[i], branchesBuilt);
			if (instrCls[i] == sparcCtrlPkg::ClsBranch)
				branchesBuilt++;
		end
		repeat (3) @(posedge Clk);
		RESET <= 1'b0;
	end

	// Memory responder, instruction stream and access tracking
	always @(posedge Clk)
	begin
		logic condDraw;
		condDraw = 1'($urandom_range(1, 0));
		if (RESET)
			resetEdges <= resetEdges + 1;
		else
		begin
			Mfc <= 1'b0;
			if (Ctrl.RamEn && !Mfc)
			begin
				if (mfcDelay == 0)
				begin
					Mfc <= 1'b1;
					mfcDelay <= $urandom_range(3, 0);
				end
				else
					mfcDelay <= mfcDelay - 1;
			end
			if (Ctrl.NpcEn && !marSeen)
				rstNpcPulses <= rstNpcPulses + 1;
			if (Ctrl.MarEn)
			begin
				marSeen <= 1'b1;
				accIsFetch <= !dataPending;
				accIsStore <= dataPending && trk.cls == sparcCtrlPkg::ClsStore;
				dataPending <= 1'b0;
				if (!dataPending && presented == NUM_INSTR)
					finished <= 1'b1; // Last instruction done
			end
			if (Ctrl.IrEn && presented < NUM_INSTR)
			begin
				Ir <= instrList[presented];
				Cond <= condDraw;
				trk <= expectedFields(instrList[presented], instrCls[presented], condDraw);
				dataPending <= instrCls[presented] inside {sparcCtrlPkg::ClsLoad,
					sparcCtrlPkg::ClsStore};
				presented <= presented + 1;
			end
		end
	end

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: %0d of %0d instructions done in %0d cycles", presented,
				NUM_INSTR, cycleCount);
			$display("TB FAILED");
			$finish;
		end
		else if (finished)
		begin
			$display("Summary: %0d errors, %0d instructions, %0d cycles", errorCount,
				presented, cycleCount);
			if (errorCount == 0)
				$display("TB PASSED");
			else
				$display("TB FAILED");
			$finish;
		end
	end

	// Reset
	assert property (@(posedge Clk) RESET && resetEdges > 0 |-> allClears && !anyEnable)
		else fault("clears low or an enable high while RESET is high");
	assert property (@(posedge Clk) $fell(RESET) |-> allClears && !anyEnable)
		else fault("clears not held in the first cycle after reset");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.MarEn && !marSeen
		|-> rstNpcPulses == 1)
		else mismatch("reset_npc_pulses", 1, $sampled(rstNpcPulses));

	// Memory handshake
	assert property (@(posedge Clk) disable iff (RESET) $rose(Ctrl.RamEn) && !accIsStore
		|-> $past(Ctrl.MarEn))
		else fault("RamEn rose without MarEn in the cycle before");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.RamEn && !Mfc |=> Ctrl.RamEn)
		else fault("RamEn dropped before Mfc");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.RamEn && Mfc |=> !Ctrl.RamEn)
		else fault("RamEn still high after Mfc");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.RamEn && Mfc && accIsFetch
		|=> Ctrl.IrEn)
		else fault("no IrEn after the fetch completed");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.RamEn && !accIsFetch
		|-> Ctrl.RamOpCode == trk.op3)
		else mismatch("ram_opcode", $sampled(trk.op3), $sampled(Ctrl.RamOpCode));

	// Arithmetic
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith |-> Ctrl.WrAddr == trk.rd)
		else mismatch("arith_wr_addr", $sampled(trk.rd), $sampled(Ctrl.WrAddr));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith |-> Ctrl.ReadA == trk.rs1)
		else mismatch("arith_read_a", $sampled(trk.rs1), $sampled(Ctrl.ReadA));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith |-> Ctrl.AluOp == trk.op3)
		else mismatch("arith_alu_op", $sampled(trk.op3), $sampled(Ctrl.AluOp));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith && !trk.imm
		|-> Ctrl.ReadB == trk.rs2)
		else mismatch("arith_read_b", $sampled(trk.rs2), $sampled(Ctrl.ReadB));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith && trk.imm
		|-> Ctrl.AluBSel == sparcCtrlPkg::AluBExt)
		else mismatch("arith_alu_b_sel", sparcCtrlPkg::AluBExt, $sampled(Ctrl.AluBSel));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith |-> Ctrl.PsrEn == trk.op3[4])
		else mismatch("arith_psr_en", $sampled(trk.op3[4]), $sampled(Ctrl.PsrEn));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.PsrEn |-> Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsArith)
		else fault("PsrEn outside an arithmetic write");

	// Loads and stores
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsLoad |-> Ctrl.WrAddr == trk.rd)
		else mismatch("load_wr_addr", $sampled(trk.rd), $sampled(Ctrl.WrAddr));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsLoad |-> $past(Ctrl.MdrEn))
		else fault("load write back without MdrEn in the cycle before");
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite |-> trk.cls != sparcCtrlPkg::ClsStore)
		else fault("register write during a store");
	assert property (@(posedge Clk) disable iff (RESET) $rose(Ctrl.RamEn) && accIsStore
		|-> $past(Ctrl.MdrEn))
		else fault("store RamEn without MdrEn in the cycle before");

	// CALL and SETHI
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsCall |-> Ctrl.WrAddr == 5'd15)
		else mismatch("call_wr_addr", 15, $sampled(Ctrl.WrAddr));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsCall |-> Ctrl.PcEn)
		else fault("CALL link write without PcEn");
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.NpcEn && trk.cls == sparcCtrlPkg::ClsCall
		|-> $past(Ctrl.PcEn, 2) && $past(Ctrl.RegWrite, 2))
		else fault("CALL NpcEn not two cycles after the link write");
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsSethi |-> Ctrl.WrAddr == trk.rd)
		else mismatch("sethi_wr_addr", $sampled(trk.rd), $sampled(Ctrl.WrAddr));
	assert property (@(posedge Clk) disable iff (RESET)
		Ctrl.RegWrite && trk.cls == sparcCtrlPkg::ClsSethi
		|-> Ctrl.ExtSel == sparcCtrlPkg::ExtImm22)
		else mismatch("sethi_ext_sel", sparcCtrlPkg::ExtImm22, $sampled(Ctrl.ExtSel));

	// Branches, checked at the next fetch
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.MarEn && trk.jump
		|-> $past(Ctrl.PcEn, 2) && $past(Ctrl.NpcEn, 2) && !$past(Ctrl.PcEn)
		&& !$past(Ctrl.NpcEn))
		else fault("taken branch did not load PC and nPC together before fetch");
	assert property (@(posedge Clk) disable iff (RESET) Ctrl.MarEn && trk.skip
		|-> $past(Ctrl.NpcEn, 4) && !$past(Ctrl.PcEn, 4) && $past(Ctrl.PcEn, 3)
		&& !$past(Ctrl.NpcEn, 3) && $past(Ctrl.NpcEn, 2) && !$past(Ctrl.PcEn, 2))
		else fault("annulled branch did not pulse NpcEn, PcEn, NpcEn in turn");

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/100ps
`include "ctrl_params.svh"

module controlUnit (
	input  logic                    Clk,
	input  logic                    RESET,
	input  logic [`INSTR_W-1:0]     Ir,
	input  logic                    Mfc,
	input  logic                    Cond, // Condition outcome from outside
	output sparcCtrlPkg::ctrlWord_t Ctrl
);

	sparcCtrlPkg::decodedInstr_t Decoded;
	sparcCtrlPkg::ctrlState_e NextState;

	instrDecoder decoder (
		.Ir      (Ir),
		.Decoded (Decoded)
	);

	ctrlSequencer sequencer (
		.Clk       (Clk),
		.RESET     (RESET),
		.Decoded   (Decoded),
		.Mfc       (Mfc),
		.Cond      (Cond),
		.State     (),
		.NextState (NextState)
	);

	ctrlWordGen wordGen (
		.Clk       (Clk),
		.RESET     (RESET),
		.NextState (NextState),
		.Decoded   (Decoded),
		.Ctrl      (Ctrl)
	);

endmodule

/* verilog/ctrlSequencer.sv */
`timescale 1ns/100ps

module ctrlSequencer (
	input  logic                        Clk,
	input  logic                        RESET,
	input  sparcCtrlPkg::decodedInstr_t Decoded,
	input  logic                        Mfc,
	input  logic                        Cond,
	output sparcCtrlPkg::ctrlState_e    State,
	output sparcCtrlPkg::ctrlState_e    NextState
);

	sparcCtrlPkg::ctrlState_e operandState;
	sparcCtrlPkg::ctrlState_e afterOperand;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			State <= sparcCtrlPkg::StReset;
		else
			State <= NextState;
	end

	always_comb
	begin
		if (Decoded.imm)
			operandState = sparcCtrlPkg::StOpImm;
		else
			operandState = sparcCtrlPkg::StOpReg;
	end

	// Where the shared operand states hand back to
	always_comb
	begin
		case (Decoded.cls)
			sparcCtrlPkg::ClsArith: afterOperand = sparcCtrlPkg::StArithWrite;
			sparcCtrlPkg::ClsLoad:  afterOperand = sparcCtrlPkg::StLoadMar;
			sparcCtrlPkg::ClsStore: afterOperand = sparcCtrlPkg::StStoreMar;
			default:                afterOperand = sparcCtrlPkg::StJmplNpc;
		endcase
	end

	always_comb
	begin
		NextState = sparcCtrlPkg::StFetchAddr;
		case (State)
			sparcCtrlPkg::StReset:     NextState = sparcCtrlPkg::StRstAlu;
			sparcCtrlPkg::StRstAlu:    NextState = sparcCtrlPkg::StRstNpc;
			sparcCtrlPkg::StRstNpc:    NextState = sparcCtrlPkg::StRstIdle;
			sparcCtrlPkg::StFetchAddr: NextState = sparcCtrlPkg::StFetchMar;
			sparcCtrlPkg::StFetchMar:  NextState = sparcCtrlPkg::StFetchWait;
			sparcCtrlPkg::StFetchWait:
			begin
				if (Mfc)
					NextState = sparcCtrlPkg::StFetchIr;
				else
					NextState = sparcCtrlPkg::StFetchWait;
			end
			sparcCtrlPkg::StFetchIr: NextState = sparcCtrlPkg::StDecode;
			sparcCtrlPkg::StDecode:
			begin
				case (Decoded.cls)
					sparcCtrlPkg::ClsSethi:  NextState = sparcCtrlPkg::StSethiSetup;
					sparcCtrlPkg::ClsBranch: NextState = sparcCtrlPkg::StBranch;
					sparcCtrlPkg::ClsCall:   NextState = sparcCtrlPkg::StCallSetup;
					sparcCtrlPkg::ClsJmpl:   NextState = sparcCtrlPkg::StJmplSetup;
					sparcCtrlPkg::ClsArith:  NextState = sparcCtrlPkg::StArithSetup;
					sparcCtrlPkg::ClsLoad:   NextState = sparcCtrlPkg::StLoadSetup;
					sparcCtrlPkg::ClsStore:  NextState = sparcCtrlPkg::StStoreSetup;
					default:                 NextState = sparcCtrlPkg::StIllegal;
				endcase
			end
			sparcCtrlPkg::StPcSetup:    NextState = sparcCtrlPkg::StPcLoad;
			sparcCtrlPkg::StPcLoad:     NextState = sparcCtrlPkg::StPcRelease;
			sparcCtrlPkg::StSethiSetup: NextState = sparcCtrlPkg::StSethiWrite;
			sparcCtrlPkg::StSethiWrite: NextState = sparcCtrlPkg::StPcSetup;
			sparcCtrlPkg::StArithSetup: NextState = operandState;
			sparcCtrlPkg::StLoadSetup:  NextState = operandState;
			sparcCtrlPkg::StStoreSetup: NextState = operandState;
			sparcCtrlPkg::StJmplLink:   NextState = operandState;
			sparcCtrlPkg::StOpImm:      NextState = afterOperand;
			sparcCtrlPkg::StOpReg:      NextState = afterOperand;
			sparcCtrlPkg::StArithWrite: NextState = sparcCtrlPkg::StPcSetup;
			sparcCtrlPkg::StLoadMar:    NextState = sparcCtrlPkg::StLoadWait;
			sparcCtrlPkg::StLoadWait:
			begin
				if (Mfc)
					NextState = sparcCtrlPkg::StLoadMdr;
				else
					NextState = sparcCtrlPkg::StLoadWait;
			end
			sparcCtrlPkg::StLoadMdr:   NextState = sparcCtrlPkg::StLoadWrite;
			sparcCtrlPkg::StLoadWrite: NextState = sparcCtrlPkg::StPcSetup;
			sparcCtrlPkg::StStoreMar:  NextState = sparcCtrlPkg::StStoreData;
			sparcCtrlPkg::StStoreData: NextState = sparcCtrlPkg::StStoreMdr;
			sparcCtrlPkg::StStoreMdr:  NextState = sparcCtrlPkg::StStoreWait;
			sparcCtrlPkg::StStoreWait:
			begin
				if (Mfc)
					NextState = sparcCtrlPkg::StPcSetup;
				else
					NextState = sparcCtrlPkg::StStoreWait;
			end
			sparcCtrlPkg::StCallSetup:  NextState = sparcCtrlPkg::StCallLink;
			sparcCtrlPkg::StCallLink:   NextState = sparcCtrlPkg::StCallTarget;
			sparcCtrlPkg::StCallTarget: NextState = sparcCtrlPkg::StCallNpc;
			sparcCtrlPkg::StJmplSetup:  NextState = sparcCtrlPkg::StJmplLink;
			sparcCtrlPkg::StBranch:
			begin
				// Only BA,a annuls a taken delay slot
				if (Decoded.brKind == sparcCtrlPkg::BrAlways)
				begin
					if (Decoded.annul)
						NextState = sparcCtrlPkg::StBrAlwaysAnnul;
					else
						NextState = sparcCtrlPkg::StBrTaken;
				end
				else if (Decoded.brKind == sparcCtrlPkg::BrCond && Cond)
					NextState = sparcCtrlPkg::StBrTaken;
				else if (Decoded.annul)
					NextState = sparcCtrlPkg::StBrSkip; // Not taken, skip delay slot
				else
					NextState = sparcCtrlPkg::StPcSetup;
			end
			sparcCtrlPkg::StBrTaken:       NextState = sparcCtrlPkg::StBrTakenLoad;
			sparcCtrlPkg::StBrAlwaysAnnul: NextState = sparcCtrlPkg::StBrTargetNpc;
			sparcCtrlPkg::StBrTargetNpc:   NextState = sparcCtrlPkg::StBrSkipPc;
			sparcCtrlPkg::StBrSkip:        NextState = sparcCtrlPkg::StBrSkipNpc;
			sparcCtrlPkg::StBrSkipNpc:     NextState = sparcCtrlPkg::StBrSkipPc;
			sparcCtrlPkg::StBrSkipPc:      NextState = sparcCtrlPkg::StBrSkipNpc2;
			sparcCtrlPkg::StIllegal:       NextState = sparcCtrlPkg::StPcSetup; // No-op
			default:                       NextState = sparcCtrlPkg::StFetchAddr;
		endcase
	end

	// Memory stall holds the sequencer in place
	assert property (@(posedge Clk) disable iff (RESET)
		(State inside {sparcCtrlPkg::StFetchWait, sparcCtrlPkg::StLoadWait,
			sparcCtrlPkg::StStoreWait}) && !Mfc |=> State == $past(State))
		else $error("wait state left without Mfc");

	assert property (@(posedge Clk) disable iff (RESET)
		State == sparcCtrlPkg::StDecode |=> State inside {sparcCtrlPkg::StSethiSetup,
			sparcCtrlPkg::StBranch, sparcCtrlPkg::StCallSetup, sparcCtrlPkg::StJmplSetup,
			sparcCtrlPkg::StArithSetup, sparcCtrlPkg::StLoadSetup,
			sparcCtrlPkg::StStoreSetup, sparcCtrlPkg::StIllegal})
		else $error("decode not followed by a class state");

endmodule

/* verilog/ctrlWordGen.sv */
`timescale 1ns/100ps
`include "ctrl_params.svh"

module ctrlWordGen (
	input  logic                        Clk,
	input  logic                        RESET,
	input  sparcCtrlPkg::ctrlState_e    NextState,
	input  sparcCtrlPkg::decodedInstr_t Decoded,
	output sparcCtrlPkg::ctrlWord_t     Ctrl
);

	// Word for the state being entered so outputs move only at edges
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			Ctrl <= '0;
			Ctrl.PcClr <= 1'b1;
			Ctrl.TrPrClr <= 1'b1;
			Ctrl.TbrClr <= 1'b1;
			Ctrl.PsrClr <= 1'b1;
		end
		else
		begin
			Ctrl.PcClr <= 1'b0;
			Ctrl.TrPrClr <= 1'b0;
			Ctrl.TbrClr <= 1'b0;
			Ctrl.PsrClr <= 1'b0;

			// One-cycle strobes
			Ctrl.IrEn <= NextState == sparcCtrlPkg::StFetchIr;
			Ctrl.NpcEn <= NextState inside {sparcCtrlPkg::StRstNpc, sparcCtrlPkg::StPcLoad,
				sparcCtrlPkg::StCallNpc, sparcCtrlPkg::StJmplNpc, sparcCtrlPkg::StBrTakenLoad,
				sparcCtrlPkg::StBrTargetNpc, sparcCtrlPkg::StBrSkipNpc, sparcCtrlPkg::StBrSkipNpc2};
			Ctrl.PcEn <= NextState inside {sparcCtrlPkg::StPcLoad, sparcCtrlPkg::StCallLink,
				sparcCtrlPkg::StJmplLink, sparcCtrlPkg::StBrTakenLoad, sparcCtrlPkg::StBrSkipPc};
			Ctrl.MdrEn <= NextState inside {sparcCtrlPkg::StLoadMdr, sparcCtrlPkg::StStoreMdr};
			Ctrl.MarEn <= NextState inside {sparcCtrlPkg::StFetchMar, sparcCtrlPkg::StLoadMar,
				sparcCtrlPkg::StStoreMar};
			Ctrl.RegWrite <= NextState inside {sparcCtrlPkg::StSethiWrite,
				sparcCtrlPkg::StArithWrite, sparcCtrlPkg::StLoadWrite, sparcCtrlPkg::StCallLink,
				sparcCtrlPkg::StJmplLink};
			// Level request held by the wait states until Mfc
			Ctrl.RamEn <= NextState inside {sparcCtrlPkg::StFetchWait, sparcCtrlPkg::StLoadWait,
				sparcCtrlPkg::StStoreWait};
			Ctrl.PsrEn <= NextState == sparcCtrlPkg::StArithWrite && Decoded.setsFlags;

			case (NextState)
				sparcCtrlPkg::StRstAlu:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluAPc; // PC is zero after the clear
					Ctrl.AluBSel <= sparcCtrlPkg::AluBConst4;
					Ctrl.ReadA <= `ZERO_REG;
					Ctrl.AluOp <= `ALU_ADD;
				end
				sparcCtrlPkg::StFetchAddr:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= `ZERO_REG; // r0 + PC
					Ctrl.AluBSel <= sparcCtrlPkg::AluBPc;
					Ctrl.AluOp <= `ALU_ADD;
				end
				sparcCtrlPkg::StFetchMar: Ctrl.RamOpCode <= `RAM_FETCH_OP;
				sparcCtrlPkg::StPcSetup, sparcCtrlPkg::StBrSkip, sparcCtrlPkg::StBrSkipPc:
				begin
					// nPC + 4 toward nPC, nPC toward PC
					Ctrl.AluASel <= sparcCtrlPkg::AluANpc;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBConst4;
					Ctrl.AluOp <= `ALU_ADD;
					Ctrl.PcInSel <= sparcCtrlPkg::PcInNpc;
				end
				sparcCtrlPkg::StSethiSetup:
				begin
					Ctrl.ExtSel <= sparcCtrlPkg::ExtImm22;
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= `ZERO_REG;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBExt;
					Ctrl.WrAddr <= Decoded.rd;
					Ctrl.AluOp <= `ALU_ADD;
				end
				sparcCtrlPkg::StArithSetup:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= Decoded.rs1;
					Ctrl.WrAddr <= Decoded.rd;
					Ctrl.AluOp <= Decoded.op3;
					Ctrl.PsrSel <= `PSR_FROM_ALU;
				end
				sparcCtrlPkg::StLoadSetup, sparcCtrlPkg::StStoreSetup:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= Decoded.rs1; // Address is rs1 + operand B
					Ctrl.WrAddr <= Decoded.rd;
					Ctrl.AluOp <= `ALU_ADD;
					Ctrl.RamOpCode <= Decoded.op3;
				end
				sparcCtrlPkg::StOpImm:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= Decoded.rs1;
					Ctrl.ExtSel <= sparcCtrlPkg::ExtSimm13;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBExt;
				end
				sparcCtrlPkg::StOpReg:
				begin
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= Decoded.rs1;
					Ctrl.ReadB <= Decoded.rs2;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBRegB;
				end
				sparcCtrlPkg::StLoadWait:
				begin
					Ctrl.MdrSel <= 1'b1;
					Ctrl.ReadA <= `ZERO_REG; // r0 + MDR for the write back
					Ctrl.AluBSel <= sparcCtrlPkg::AluBMdr;
				end
				sparcCtrlPkg::StStoreData:
				begin
					Ctrl.ReadA <= Decoded.rd;
					Ctrl.ReadB <= `ZERO_REG;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBRegB;
					Ctrl.MdrSel <= 1'b0;
				end
				sparcCtrlPkg::StCallSetup, sparcCtrlPkg::StJmplSetup:
				begin
					if (Decoded.cls == sparcCtrlPkg::ClsCall)
						Ctrl.WrAddr <= `LINK_REG;
					else
						Ctrl.WrAddr <= Decoded.rd;
					Ctrl.AluASel <= sparcCtrlPkg::AluARegA;
					Ctrl.ReadA <= `ZERO_REG;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBPc;
					Ctrl.AluOp <= `ALU_ADD;
					Ctrl.PcInSel <= sparcCtrlPkg::PcInNpc;
				end
				sparcCtrlPkg::StCallTarget:
				begin
					Ctrl.ReadA <= `LINK_REG; // Saved PC + disp30 * 4
					Ctrl.AluBSel <= sparcCtrlPkg::AluBExt;
					Ctrl.ExtSel <= sparcCtrlPkg::ExtDisp30;
				end
				sparcCtrlPkg::StBrTaken, sparcCtrlPkg::StBrAlwaysAnnul:
				begin
					Ctrl.ExtSel <= sparcCtrlPkg::ExtDisp22;
					Ctrl.AluASel <= sparcCtrlPkg::AluAPc;
					Ctrl.AluBSel <= sparcCtrlPkg::AluBExt;
					Ctrl.AluOp <= `ALU_ADD;
					Ctrl.PcInSel <= sparcCtrlPkg::PcInNpc;
				end
				default: ;
			endcase
		end
	end

	assert property (@(posedge Clk)
		Ctrl.PcClr |-> !(Ctrl.IrEn || Ctrl.NpcEn || Ctrl.PcEn || Ctrl.MdrEn || Ctrl.MarEn
			|| Ctrl.RegWrite || Ctrl.RamEn || Ctrl.PsrEn))
		else $error("enable active during clear");

	assert property (@(posedge Clk) disable iff (RESET) !(Ctrl.MarEn && Ctrl.RamEn))
		else $error("MarEn and RamEn overlap");

endmodule

/* verilog/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Instruction word layout
`define INSTR_W 32
`define OP_HI 31
`define OP_LO 30
`define RD_HI 29
`define RD_LO 25
`define ANNUL_BIT 29
`define COND_HI 28
`define COND_LO 25
`define OP2_HI 24
`define OP2_LO 22
`define OP3_HI 24
`define OP3_LO 19
`define RS1_HI 18
`define RS1_LO 14
`define IMM_BIT 13
`define RS2_HI 4
`define RS2_LO 0
`define FLAG_BIT 4 // Inside op3, the cc variants

`define REG_ADDR_W 5
`define OP3_W 6
`define PSR_SEL_W 3

`define ZERO_REG 5'd0
`define LINK_REG 5'd15 // CALL writes the return address here
`define ALU_ADD 6'd0
`define RAM_FETCH_OP 6'd0 // Word load opcode used by fetch
`define PSR_FROM_ALU 3'd0
`define NPC_RESET_INC 32'd4 // Value of the ALU constant-four input

`endif

/* verilog/instrDecoder.sv */
`timescale 1ns/100ps
`include "ctrl_params.svh"

module instrDecoder (
	input  logic [`INSTR_W-1:0]        Ir,
	output sparcCtrlPkg::decodedInstr_t Decoded
);

	logic [1:0] opField;
	logic [2:0] op2;
	logic [`OP3_W-1:0] op3;
	logic [3:0] cond;
	logic isLoad;
	logic isStore;
	logic isArith;

	assign opField = Ir[`OP_HI:`OP_LO];
	assign op2 = Ir[`OP2_HI:`OP2_LO];
	assign op3 = Ir[`OP3_HI:`OP3_LO];
	assign cond = Ir[`COND_HI:`COND_LO];

	// Word, unsigned byte/half and signed byte/half loads
	assign isLoad = op3 inside {6'b000000, 6'b000001, 6'b000010, 6'b001001, 6'b001010};
	assign isStore = op3 inside {6'b000100, 6'b000101, 6'b000110};
	// ALU group plus the three shifts
	assign isArith = !op3[5] || (op3 inside {6'b100101, 6'b100110, 6'b100111});

	always_comb
	begin
		Decoded.rd = Ir[`RD_HI:`RD_LO];
		Decoded.rs1 = Ir[`RS1_HI:`RS1_LO];
		Decoded.rs2 = Ir[`RS2_HI:`RS2_LO];
		Decoded.imm = Ir[`IMM_BIT];
		Decoded.annul = Ir[`ANNUL_BIT];
		Decoded.op3 = op3;
		Decoded.cls = sparcCtrlPkg::ClsIllegal;

		if (cond == 4'b1000)
			Decoded.brKind = sparcCtrlPkg::BrAlways;
		else if (cond == 4'b0000)
			Decoded.brKind = sparcCtrlPkg::BrNever;
		else
			Decoded.brKind = sparcCtrlPkg::BrCond;

		case (opField)
			2'b00:
			begin
				if (op2 == 3'b100)
					Decoded.cls = sparcCtrlPkg::ClsSethi;
				else if (op2 == 3'b010)
					Decoded.cls = sparcCtrlPkg::ClsBranch; // Bicc only
			end
			2'b01: Decoded.cls = sparcCtrlPkg::ClsCall;
			2'b10:
			begin
				if (op3 == 6'b111000)
					Decoded.cls = sparcCtrlPkg::ClsJmpl;
				else if (isArith)
					Decoded.cls = sparcCtrlPkg::ClsArith;
			end
			default:
			begin
				if (isLoad)
					Decoded.cls = sparcCtrlPkg::ClsLoad;
				else if (isStore)
					Decoded.cls = sparcCtrlPkg::ClsStore;
			end
		endcase

		// cc variants update the flags
		Decoded.setsFlags = (Decoded.cls == sparcCtrlPkg::ClsArith) && op3[`FLAG_BIT];
	end

endmodule

/* verilog/sparcCtrlPkg.sv */
`include "ctrl_params.svh"

package sparcCtrlPkg;

	typedef enum logic [2:0]
	{
		ClsSethi,
		ClsBranch,
		ClsCall,
		ClsJmpl,
		ClsArith,
		ClsLoad,
		ClsStore,
		ClsIllegal
	} instrClass_e;

	typedef enum logic [1:0]
	{
		BrAlways,
		BrNever,
		BrCond
	} branchKind_e;

	// One state per microstep, reset state first
	typedef enum logic [6:0]
	{
		StReset, StRstAlu, StRstNpc, StRstIdle,
		StFetchAddr, StFetchMar, StFetchWait, StFetchIr, StDecode,
		StPcSetup, StPcLoad, StPcRelease,
		StSethiSetup, StSethiWrite,
		StArithSetup, StArithWrite,
		StOpImm, StOpReg, // Operand B, shared by arith, memory and JMPL
		StLoadSetup, StLoadMar, StLoadWait, StLoadMdr, StLoadWrite,
		StStoreSetup, StStoreMar, StStoreData, StStoreMdr, StStoreWait,
		StCallSetup, StCallLink, StCallTarget, StCallNpc,
		StJmplSetup, StJmplLink, StJmplNpc,
		StBranch, StBrTaken, StBrTakenLoad, StBrAlwaysAnnul, StBrTargetNpc,
		StBrSkip, StBrSkipNpc, StBrSkipPc, StBrSkipNpc2,
		StIllegal
	} ctrlState_e;

	typedef enum logic [1:0]
	{
		AluARegA = 2'b00,
		AluAPc   = 2'b01,
		AluANpc  = 2'b10
	} aluASel_e;

	typedef enum logic [3:0]
	{
		AluBRegB   = 4'b0000,
		AluBExt    = 4'b0001,
		AluBMdr    = 4'b0010,
		AluBPc     = 4'b0011,
		AluBConst4 = 4'b0110
	} aluBSel_e;

	typedef enum logic [2:0]
	{
		ExtSimm13 = 3'b000,
		ExtDisp30 = 3'b011, // Word displacement times 4
		ExtImm22  = 3'b100, // Placed in the high bits
		ExtDisp22 = 3'b101
	} extSel_e;

	typedef enum logic [1:0]
	{
		PcInNpc = 2'b00,
		PcInAlu = 2'b01,
		PcInTbr = 2'b10
	} pcInSel_e;

	typedef struct packed
	{
		instrClass_e cls;
		branchKind_e brKind;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic imm;
		logic annul;
		logic [`OP3_W-1:0] op3;
		logic setsFlags;
	} decodedInstr_t;

	typedef struct packed
	{
		logic IrEn;
		logic NpcEn;
		logic PcEn;
		logic MdrEn;
		logic MarEn;
		logic RegWrite;
		logic RamEn;
		logic PsrEn;
		logic PcClr;
		logic TrPrClr;
		logic TbrClr;
		logic PsrClr;
		aluASel_e AluASel;
		aluBSel_e AluBSel;
		extSel_e ExtSel;
		pcInSel_e PcInSel;
		logic [`PSR_SEL_W-1:0] PsrSel;
		logic MdrSel; // 1 takes the RAM data, 0 the ALU
		logic [`REG_ADDR_W-1:0] WrAddr;
		logic [`REG_ADDR_W-1:0] ReadA;
		logic [`REG_ADDR_W-1:0] ReadB;
		logic [`OP3_W-1:0] AluOp;
		logic [`OP3_W-1:0] RamOpCode;
	} ctrlWord_t;

endpackage

/* vlog.f */
+incdir+verilog
verilog/sparcCtrlPkg.sv
verilog/instrDecoder.sv
verilog/ctrlSequencer.sv
verilog/ctrlWordGen.sv
verilog/controlUnit.sv
tb/controlUnitTb.sv
